/* Makefile */
# Verilator build for the reorder buffer

VERILATOR ?= verilator
TOP ?= tb_rob
FILELIST ?= src.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
PASS_MSG ?= Simulation completed successfully
VFLAGS ?= --timing --assert
JOBS ?= 0

SOURCES := $(wildcard rtl/*.sv rtl/*.svh tests/*.sv)
BINARY := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# the log decides the result, not the exit status of the run
sim: $(BINARY)
	./$(BINARY) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* rtl/rob_bank.sv */
// reorder buffer thread bank
`timescale 1ns/10ps
`include "rob_consts.svh"

module rob_bank
#(
	parameter bit bank_id = 1'b0	// 0 for thread 1, 1 for thread 2
)
(
	input	logic					clock,
	input	logic					reset,

	input	rob_pkg::retire_cnt_t	alloc_count,	// already gated by full in the top
	input	rob_pkg::pc_t			new1_pc,
	input	rob_pkg::pc_t			new2_pc,
	input	rob_pkg::arn_t			new1_arn,
	input	rob_pkg::arn_t			new2_arn,
	input	rob_pkg::prn_t			new1_prn,
	input	rob_pkg::prn_t			new2_prn,
	input	logic					new1_branch,
	input	logic					new2_branch,

	input	logic					fu1_done,
	input	rob_pkg::rob_idx_t		fu1_rob_idx,
	input	logic					fu1_mispredict,
	input	rob_pkg::pc_t			fu1_target_pc,
	input	logic					fu2_done,
	input	rob_pkg::rob_idx_t		fu2_rob_idx,
	input	logic					fu2_mispredict,
	input	rob_pkg::pc_t			fu2_target_pc,

	input	rob_pkg::retire_cnt_t	retire_count,
	input	logic					flush,

	output	rob_pkg::bank_idx_t		tail,
	output	logic					full,
	output	logic					slot0_ready,
	output	logic					slot1_ready,
	output	rob_pkg::pc_t			slot0_pc,
	output	rob_pkg::pc_t			slot1_pc,
	output	rob_pkg::pc_t			slot0_target_pc,
	output	rob_pkg::pc_t			slot1_target_pc,
	output	logic					slot0_branch,
	output	logic					slot1_branch,
	output	logic					slot0_mispredict,
	output	logic					slot1_mispredict,
	output	rob_pkg::arn_t			slot0_arn,
	output	rob_pkg::arn_t			slot1_arn,
	output	rob_pkg::prn_t			slot0_prn,
	output	rob_pkg::prn_t			slot1_prn
);

	import rob_pkg::*;

	typedef logic [`ROB_IDX_W:0] cnt_t;		// occupancy, 0 up to ROB_SIZE

	pc_t					pc_q [`ROB_SIZE];
	pc_t					target_q [`ROB_SIZE];
	arn_t					arn_q [`ROB_SIZE];
	prn_t					prn_q [`ROB_SIZE];
	logic					branch_q [`ROB_SIZE];
	logic					mispredict_q [`ROB_SIZE];
	logic [`ROB_SIZE-1:0]	valid_q;		// allocated
	logic [`ROB_SIZE-1:0]	executed_q;		// written back by a function unit

	bank_idx_t	head;
	bank_idx_t	head_plus1;
	bank_idx_t	head_next;
	bank_idx_t	tail_plus1;
	cnt_t		count;
	bank_idx_t	fu1_pos;
	bank_idx_t	fu2_pos;
	logic		fu1_hit;
	logic		fu2_hit;

	assign head_plus1 = head + bank_idx_t'(1);
	assign head_next = head + bank_idx_t'(retire_count);
	assign tail_plus1 = tail + bank_idx_t'(1);

	// a writeback counts only for this thread and a live entry
	assign fu1_pos = fu1_rob_idx[`ROB_IDX_W-1:0];
	assign fu2_pos = fu2_rob_idx[`ROB_IDX_W-1:0];
	assign fu1_hit = fu1_done && (fu1_rob_idx[`ROB_IDX_W] == bank_id) && valid_q[fu1_pos];
	assign fu2_hit = fu2_done && (fu2_rob_idx[`ROB_IDX_W] == bank_id) && valid_q[fu2_pos];

	assign full = count > cnt_t'(`ROB_SIZE - 2);	// fewer than two free

	// head and the entry behind it, seen by the commit selector
	assign slot0_ready = valid_q[head] && executed_q[head];
	assign slot0_pc = pc_q[head];
	assign slot0_target_pc = target_q[head];
	assign slot0_branch = branch_q[head];
	assign slot0_mispredict = mispredict_q[head];
	assign slot0_arn = arn_q[head];
	assign slot0_prn = prn_q[head];

	assign slot1_ready = valid_q[head_plus1] && executed_q[head_plus1];
	assign slot1_pc = pc_q[head_plus1];
	assign slot1_target_pc = target_q[head_plus1];
	assign slot1_branch = branch_q[head_plus1];
	assign slot1_mispredict = mispredict_q[head_plus1];
	assign slot1_arn = arn_q[head_plus1];
	assign slot1_prn = prn_q[head_plus1];

	// entry payload
	always_ff @(posedge clock)
	begin
		if (alloc_count != 2'd0 && !flush)
		begin
			pc_q[tail] <= new1_pc;
			arn_q[tail] <= new1_arn;
			prn_q[tail] <= new1_prn;
			branch_q[tail] <= new1_branch;
		end
		if (alloc_count == 2'd2 && !flush)
		begin
			pc_q[tail_plus1] <= new2_pc;
			arn_q[tail_plus1] <= new2_arn;
			prn_q[tail_plus1] <= new2_prn;
			branch_q[tail_plus1] <= new2_branch;
		end
		if (fu1_hit)
		begin
			target_q[fu1_pos] <= fu1_target_pc;
			mispredict_q[fu1_pos] <= fu1_mispredict;
		end
		if (fu2_hit)
		begin
			target_q[fu2_pos] <= fu2_target_pc;
			mispredict_q[fu2_pos] <= fu2_mispredict;
		end
	end

	// pointers, count and entry status
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			head <= '0;
			tail <= '0;
			count <= '0;
			valid_q <= '0;
			executed_q <= '0;
		end
		else if (flush)
		begin
			// younger entries are dropped, tail snaps to the new head
			head <= head_next;
			tail <= head_next;
			count <= '0;
			valid_q <= '0;
			executed_q <= '0;
		end
		else
		begin
			head <= head_next;
			tail <= tail + bank_idx_t'(alloc_count);
			count <= count + cnt_t'(alloc_count) - cnt_t'(retire_count);
			if (fu1_hit)
				executed_q[fu1_pos] <= 1'b1;
			if (fu2_hit)
				executed_q[fu2_pos] <= 1'b1;
			if (retire_count != 2'd0)
			begin
				valid_q[head] <= 1'b0;
				executed_q[head] <= 1'b0;
			end
			if (retire_count == 2'd2)
			begin
				valid_q[head_plus1] <= 1'b0;
				executed_q[head_plus1] <= 1'b0;
			end
			if (alloc_count != 2'd0)
			begin
				valid_q[tail] <= 1'b1;
				executed_q[tail] <= 1'b0;
			end
			if (alloc_count == 2'd2)
			begin
				valid_q[tail_plus1] <= 1'b1;
				executed_q[tail_plus1] <= 1'b0;
			end
		end
	end

endmodule

/* rtl/rob_commit_select.sv */
// reorder buffer commit selector
`timescale 1ns/10ps
`include "rob_consts.svh"

module rob_commit_select
(
	input	logic					t1_slot0_ready,
	input	logic					t1_slot1_ready,
	input	rob_pkg::pc_t			t1_slot0_pc,
	input	rob_pkg::pc_t			t1_slot1_pc,
	input	rob_pkg::pc_t			t1_slot0_target_pc,
	input	rob_pkg::pc_t			t1_slot1_target_pc,
	input	logic					t1_slot0_branch,
	input	logic					t1_slot1_branch,
	input	logic					t1_slot0_mispredict,
	input	logic					t1_slot1_mispredict,
	input	rob_pkg::arn_t			t1_slot0_arn,
	input	rob_pkg::arn_t			t1_slot1_arn,
	input	rob_pkg::prn_t			t1_slot0_prn,
	input	rob_pkg::prn_t			t1_slot1_prn,

	input	logic					t2_slot0_ready,
	input	logic					t2_slot1_ready,
	input	rob_pkg::pc_t			t2_slot0_pc,
	input	rob_pkg::pc_t			t2_slot1_pc,
	input	rob_pkg::pc_t			t2_slot0_target_pc,
	input	rob_pkg::pc_t			t2_slot1_target_pc,
	input	logic					t2_slot0_branch,
	input	logic					t2_slot1_branch,
	input	logic					t2_slot0_mispredict,
	input	logic					t2_slot1_mispredict,
	input	rob_pkg::arn_t			t2_slot0_arn,
	input	rob_pkg::arn_t			t2_slot1_arn,
	input	rob_pkg::prn_t			t2_slot0_prn,
	input	rob_pkg::prn_t			t2_slot1_prn,

	output	rob_pkg::retire_cnt_t	t1_retire,
	output	rob_pkg::retire_cnt_t	t2_retire,
	output	logic					t1_flush,
	output	logic					t2_flush,

	output	logic					commit1_valid,
	output	logic					commit1_is_thread1,
	output	rob_pkg::pc_t			commit1_pc,
	output	rob_pkg::pc_t			commit1_target_pc,
	output	logic					commit1_is_branch,
	output	logic					commit1_mispredict,
	output	rob_pkg::arn_t			commit1_arn_dest,
	output	rob_pkg::prn_t			commit1_prn_dest,
	output	logic					commit2_valid,
	output	logic					commit2_is_thread1,
	output	rob_pkg::pc_t			commit2_pc,
	output	rob_pkg::pc_t			commit2_target_pc,
	output	logic					commit2_is_branch,
	output	logic					commit2_mispredict,
	output	rob_pkg::arn_t			commit2_arn_dest,
	output	rob_pkg::prn_t			commit2_prn_dest
);

	import rob_pkg::*;

	commit_src_e	src1;
	commit_src_e	src2;
	logic			kill1;		// slot 1 is a mispredicted branch
	logic			kill2;

	// slot 1 prefers the thread 1 head
	always_comb
	begin
		src1 = src_none;
		if (t1_slot0_ready)
			src1 = src_thread1;
		else if (t2_slot0_ready)
			src1 = src_thread2;
	end

	always_comb
	begin
		commit1_valid = (src1 != src_none);
		commit1_is_thread1 = (src1 == src_thread1);
		case (src1)
			src_thread1:
			begin
				commit1_pc = t1_slot0_pc;
				commit1_target_pc = t1_slot0_target_pc;
				commit1_is_branch = t1_slot0_branch;
				commit1_mispredict = t1_slot0_mispredict;
				commit1_arn_dest = t1_slot0_arn;
				commit1_prn_dest = t1_slot0_prn;
			end
			src_thread2:
			begin
				commit1_pc = t2_slot0_pc;
				commit1_target_pc = t2_slot0_target_pc;
				commit1_is_branch = t2_slot0_branch;
				commit1_mispredict = t2_slot0_mispredict;
				commit1_arn_dest = t2_slot0_arn;
				commit1_prn_dest = t2_slot0_prn;
			end
			default:
			begin
				commit1_pc = '0;
				commit1_target_pc = '0;
				commit1_is_branch = 1'b0;
				commit1_mispredict = 1'b0;
				commit1_arn_dest = `ZERO_REG;
				commit1_prn_dest = '0;
			end
		endcase
	end

	assign kill1 = commit1_is_branch && commit1_mispredict;

	// slot 2 stays in program order behind slot 1, empty after a mispredict
	always_comb
	begin
		src2 = src_none;
		if (!kill1)
		begin
			if (src1 == src_thread1)
			begin
				if (t1_slot1_ready)
					src2 = src_thread1;
				else if (t2_slot0_ready)
					src2 = src_thread2;
			end
			else if (src1 == src_thread2 && t2_slot1_ready)
				src2 = src_thread2;
		end
	end

	always_comb
	begin
		commit2_valid = (src2 != src_none);
		commit2_is_thread1 = (src2 == src_thread1);
		case (src2)
			src_thread1:	// always the entry after the thread 1 head
			begin
				commit2_pc = t1_slot1_pc;
				commit2_target_pc = t1_slot1_target_pc;
				commit2_is_branch = t1_slot1_branch;
				commit2_mispredict = t1_slot1_mispredict;
				commit2_arn_dest = t1_slot1_arn;
				commit2_prn_dest = t1_slot1_prn;
			end
			src_thread2:
			begin
				if (src1 == src_thread2)
				begin
					commit2_pc = t2_slot1_pc;
					commit2_target_pc = t2_slot1_target_pc;
					commit2_is_branch = t2_slot1_branch;
					commit2_mispredict = t2_slot1_mispredict;
					commit2_arn_dest = t2_slot1_arn;
					commit2_prn_dest = t2_slot1_prn;
				end
				else
				begin
					commit2_pc = t2_slot0_pc;
					commit2_target_pc = t2_slot0_target_pc;
					commit2_is_branch = t2_slot0_branch;
					commit2_mispredict = t2_slot0_mispredict;
					commit2_arn_dest = t2_slot0_arn;
					commit2_prn_dest = t2_slot0_prn;
				end
			end
			default:
			begin
				commit2_pc = '0;
				commit2_target_pc = '0;
				commit2_is_branch = 1'b0;
				commit2_mispredict = 1'b0;
				commit2_arn_dest = `ZERO_REG;
				commit2_prn_dest = '0;
			end
		endcase
	end

	assign kill2 = commit2_is_branch && commit2_mispredict;

	assign t1_retire = retire_cnt_t'(src1 == src_thread1) + retire_cnt_t'(src2 == src_thread1);
	assign t2_retire = retire_cnt_t'(src1 == src_thread2) + retire_cnt_t'(src2 == src_thread2);

	// the thread that commits a mispredict loses its younger entries
	assign t1_flush = (kill1 && src1 == src_thread1) || (kill2 && src2 == src_thread1);
	assign t2_flush = (kill1 && src1 == src_thread2) || (kill2 && src2 == src_thread2);

endmodule

/* rtl/rob_consts.svh */
// reorder buffer constants
`ifndef ROB_CONSTS_SVH
`define ROB_CONSTS_SVH

// entries held by each thread bank
`define ROB_SIZE	8

// position inside one bank
`define ROB_IDX_W	$clog2(`ROB_SIZE)

// physical register file
`define PRF_SIZE	64
`define PRN_W		$clog2(`PRF_SIZE)

// architected registers, 32 of them
`define ARN_W		5

// r31 reads as zero, driven on an idle commit slot
`define ZERO_REG	5'd31

`define PC_W		64

`endif

/* rtl/rob_pkg.sv */
// reorder buffer types
`include "rob_consts.svh"

package rob_pkg;

	typedef logic [`ROB_IDX_W-1:0]	bank_idx_t;		// entry position within a bank

	// global index, top bit is the thread (0 = thread 1, 1 = thread 2)
	typedef logic [`ROB_IDX_W:0]	rob_idx_t;

	typedef logic [`PC_W-1:0]		pc_t;
	typedef logic [`ARN_W-1:0]		arn_t;
	typedef logic [`PRN_W-1:0]		prn_t;

	// entries moved in one cycle, 0 to 2
	typedef logic [1:0]				retire_cnt_t;

	// where a commit slot takes its entry from
	typedef enum logic [1:0]
	{
		src_none,
		src_thread1,
		src_thread2
	} commit_src_e;

endpackage

/* rtl/rob_top.sv */
// two-thread reorder buffer
`timescale 1ns/10ps

module rob_top
(
	input	logic					clock,
	input	logic					reset,

	input	logic					is_thread1,		// both dispatched instructions belong here
	input	logic					inst1_load,
	input	rob_pkg::pc_t			inst1_pc,
	input	rob_pkg::arn_t			inst1_arn_dest,
	input	rob_pkg::prn_t			inst1_prn_dest,
	input	logic					inst1_is_branch,
	input	logic					inst2_load,		// only with inst1_load
	input	rob_pkg::pc_t			inst2_pc,
	input	rob_pkg::arn_t			inst2_arn_dest,
	input	rob_pkg::prn_t			inst2_prn_dest,
	input	logic					inst2_is_branch,

	input	logic					fu1_done,
	input	rob_pkg::rob_idx_t		fu1_rob_idx,
	input	logic					fu1_mispredict,
	input	rob_pkg::pc_t			fu1_target_pc,
	input	logic					fu2_done,
	input	rob_pkg::rob_idx_t		fu2_rob_idx,
	input	logic					fu2_mispredict,
	input	rob_pkg::pc_t			fu2_target_pc,

	output	rob_pkg::rob_idx_t		inst1_rob_idx,
	output	rob_pkg::rob_idx_t		inst2_rob_idx,
	output	logic					t1_full,
	output	logic					t2_full,

	output	logic					commit1_valid,
	output	logic					commit1_is_thread1,
	output	rob_pkg::pc_t			commit1_pc,
	output	rob_pkg::pc_t			commit1_target_pc,
	output	logic					commit1_is_branch,
	output	logic					commit1_mispredict,
	output	rob_pkg::arn_t			commit1_arn_dest,
	output	rob_pkg::prn_t			commit1_prn_dest,
	output	logic					commit2_valid,
	output	logic					commit2_is_thread1,
	output	rob_pkg::pc_t			commit2_pc,
	output	rob_pkg::pc_t			commit2_target_pc,
	output	logic					commit2_is_branch,
	output	logic					commit2_mispredict,
	output	rob_pkg::arn_t			commit2_arn_dest,
	output	rob_pkg::prn_t			commit2_prn_dest
);

	import rob_pkg::*;

	retire_cnt_t	load_count;		// instructions offered this cycle
	retire_cnt_t	t1_alloc;
	retire_cnt_t	t2_alloc;
	retire_cnt_t	taken;
	bank_idx_t		t1_tail;
	bank_idx_t		t2_tail;
	bank_idx_t		sel_tail;

	retire_cnt_t	t1_retire;
	retire_cnt_t	t2_retire;
	logic			t1_flush;
	logic			t2_flush;

	logic			t1_slot0_ready, t1_slot1_ready;
	pc_t			t1_slot0_pc, t1_slot1_pc;
	pc_t			t1_slot0_target_pc, t1_slot1_target_pc;
	logic			t1_slot0_branch, t1_slot1_branch;
	logic			t1_slot0_mispredict, t1_slot1_mispredict;
	arn_t			t1_slot0_arn, t1_slot1_arn;
	prn_t			t1_slot0_prn, t1_slot1_prn;

	logic			t2_slot0_ready, t2_slot1_ready;
	pc_t			t2_slot0_pc, t2_slot1_pc;
	pc_t			t2_slot0_target_pc, t2_slot1_target_pc;
	logic			t2_slot0_branch, t2_slot1_branch;
	logic			t2_slot0_mispredict, t2_slot1_mispredict;
	arn_t			t2_slot0_arn, t2_slot1_arn;
	prn_t			t2_slot0_prn, t2_slot1_prn;

	always_comb
	begin
		if (!inst1_load)
			load_count = 2'd0;
		else if (inst2_load)
			load_count = 2'd2;
		else
			load_count = 2'd1;
	end

	// a full or flushing thread takes nothing
	assign t1_alloc = (is_thread1 && !t1_full && !t1_flush) ? load_count : 2'd0;
	assign t2_alloc = (!is_thread1 && !t2_full && !t2_flush) ? load_count : 2'd0;

	assign taken = is_thread1 ? t1_alloc : t2_alloc;
	assign sel_tail = is_thread1 ? t1_tail : t2_tail;

	// index is thread bit over bank position, zero when not accepted
	assign inst1_rob_idx = (taken != 2'd0) ? {!is_thread1, sel_tail} : '0;
	assign inst2_rob_idx = (taken == 2'd2) ? {!is_thread1, sel_tail + bank_idx_t'(1)} : '0;

	rob_bank #(.bank_id(1'b0)) u_bank_t1
	(
		.*,
		.alloc_count		(t1_alloc),
		.new1_pc			(inst1_pc),
		.new2_pc			(inst2_pc),
		.new1_arn			(inst1_arn_dest),
		.new2_arn			(inst2_arn_dest),
		.new1_prn			(inst1_prn_dest),
		.new2_prn			(inst2_prn_dest),
		.new1_branch		(inst1_is_branch),
		.new2_branch		(inst2_is_branch),
		.retire_count		(t1_retire),
		.flush				(t1_flush),
		.tail				(t1_tail),
		.full				(t1_full),
		.slot0_ready		(t1_slot0_ready),
		.slot1_ready		(t1_slot1_ready),
		.slot0_pc			(t1_slot0_pc),
		.slot1_pc			(t1_slot1_pc),
		.slot0_target_pc	(t1_slot0_target_pc),
		.slot1_target_pc	(t1_slot1_target_pc),
		.slot0_branch		(t1_slot0_branch),
		.slot1_branch		(t1_slot1_branch),
		.slot0_mispredict	(t1_slot0_mispredict),
		.slot1_mispredict	(t1_slot1_mispredict),
		.slot0_arn			(t1_slot0_arn),
		.slot1_arn			(t1_slot1_arn),
		.slot0_prn			(t1_slot0_prn),
		.slot1_prn			(t1_slot1_prn)
	);

	rob_bank #(.bank_id(1'b1)) u_bank_t2
	(
		.*,
		.alloc_count		(t2_alloc),
		.new1_pc			(inst1_pc),
		.new2_pc			(inst2_pc),
		.new1_arn			(inst1_arn_dest),
		.new2_arn			(inst2_arn_dest),
		.new1_prn			(inst1_prn_dest),
		.new2_prn			(inst2_prn_dest),
		.new1_branch		(inst1_is_branch),
		.new2_branch		(inst2_is_branch),
		.retire_count		(t2_retire),
		.flush				(t2_flush),
		.tail				(t2_tail),
		.full				(t2_full),
		.slot0_ready		(t2_slot0_ready),
		.slot1_ready		(t2_slot1_ready),
		.slot0_pc			(t2_slot0_pc),
		.slot1_pc			(t2_slot1_pc),
		.slot0_target_pc	(t2_slot0_target_pc),
		.slot1_target_pc	(t2_slot1_target_pc),
		.slot0_branch		(t2_slot0_branch),
		.slot1_branch		(t2_slot1_branch),
		.slot0_mispredict	(t2_slot0_mispredict),
		.slot1_mispredict	(t2_slot1_mispredict),
		.slot0_arn			(t2_slot0_arn),
		.slot1_arn			(t2_slot1_arn),
		.slot0_prn			(t2_slot0_prn),
		.slot1_prn			(t2_slot1_prn)
	);

	// port names match the nets here one for one
	rob_commit_select u_commit
	(
		.*
	);

endmodule

/* src.f */
+incdir+rtl
rtl/rob_pkg.sv
rtl/rob_bank.sv
rtl/rob_commit_select.sv
rtl/rob_top.sv
tests/rob_assertions.sv
tests/tb_rob.sv

/* tests/rob_assertions.sv */
// reorder buffer assertions
`timescale 1ns/10ps

module rob_assertions
(
	input	logic	clock,
	input	logic	reset,
	input	logic	commit1_valid,
	input	logic	commit2_valid,
	input	logic	t1_flush,
	input	logic	t2_flush,
	input	logic	t1_full,
	input	logic	t2_full,
	input	logic	t1_slot0_ready,
	input	logic	t1_slot1_ready,
	input	logic	t2_slot0_ready,
	input	logic	t2_slot1_ready
);

	int unsigned error_count = 0;	// read by the testbench at the end

	// slot 2 is only ever filled behind slot 1
	commit_order: assert property (@(posedge clock) disable iff (reset)
		commit2_valid |-> commit1_valid)
	else
	begin
		error_count++;
		$error("commit2_valid high while commit1_valid is low");
	end

	t1_flush_empties: assert property (@(posedge clock) disable iff (reset)
		t1_flush |=> !t1_slot0_ready && !t1_slot1_ready && !t1_full)
	else
	begin
		error_count++;
		$error("thread 1 bank not empty after flush");
	end

	t2_flush_empties: assert property (@(posedge clock) disable iff (reset)
		t2_flush |=> !t2_slot0_ready && !t2_slot1_ready && !t2_full)
	else
	begin
		error_count++;
		$error("thread 2 bank not empty after flush");
	end

	full_after_reset: assert property (@(posedge clock)
		$past(reset) && !reset |-> !t1_full && !t2_full)
	else
	begin
		error_count++;
		$error("full flag high right after reset");
	end

endmodule

bind rob_top rob_assertions u_assert
(
	.clock,
	.reset,
	.commit1_valid,
	.commit2_valid,
	.t1_flush,
	.t2_flush,
	.t1_full,
	.t2_full,
	.t1_slot0_ready,
	.t1_slot1_ready,
	.t2_slot0_ready,
	.t2_slot1_ready
);

/* tests/tb_rob.sv */
// reorder buffer testbench
`timescale 1ns/10ps
`include "rob_consts.svh"

module tb_rob;

	import rob_pkg::*;

	localparam int half_period = 50;
	localparam int period = 2 * half_period;
	// rough cycles per test with reset included
	localparam int budget_cycles = 2 + 4 + 8 + 9 + 7 + 12;

	logic			clock;
	logic			reset;
	logic			is_thread1;
	logic			inst1_load, inst2_load;
	pc_t			inst1_pc, inst2_pc;
	arn_t			inst1_arn_dest, inst2_arn_dest;
	prn_t			inst1_prn_dest, inst2_prn_dest;
	logic			inst1_is_branch, inst2_is_branch;
	logic			fu1_done, fu2_done;
	rob_idx_t		fu1_rob_idx, fu2_rob_idx;
	logic			fu1_mispredict, fu2_mispredict;
	pc_t			fu1_target_pc, fu2_target_pc;
	rob_idx_t		inst1_rob_idx, inst2_rob_idx;
	logic			t1_full, t2_full;
	logic			commit1_valid, commit2_valid;
	logic			commit1_is_thread1, commit2_is_thread1;
	pc_t			commit1_pc, commit2_pc;
	pc_t			commit1_target_pc, commit2_target_pc;
	logic			commit1_is_branch, commit2_is_branch;
	logic			commit1_mispredict, commit2_mispredict;
	arn_t			commit1_arn_dest, commit2_arn_dest;
	prn_t			commit1_prn_dest, commit2_prn_dest;

	// expected entry contents by global ROB index
	pc_t			e_pc [2*`ROB_SIZE];
	pc_t			e_tgt [2*`ROB_SIZE];
	arn_t			e_arn [2*`ROB_SIZE];
	prn_t			e_prn [2*`ROB_SIZE];
	logic			e_br [2*`ROB_SIZE];
	logic			e_mis [2*`ROB_SIZE];

	int				seed;
	int				errors;
	int				test_errors;
	int				tests_run;
	int				tests_failed;

	rob_top u_dut (.*);

	initial clock = 1'b0;
	always #(half_period) clock = ~clock;

	task automatic drive_idle();
		is_thread1 = 1'b1;
		inst1_load = 1'b0;
		inst2_load = 1'b0;
		inst1_pc = '0;
		inst2_pc = '0;
		inst1_arn_dest = '0;
		inst2_arn_dest = '0;
		inst1_prn_dest = '0;
		inst2_prn_dest = '0;
		inst1_is_branch = 1'b0;
		inst2_is_branch = 1'b0;
		fu1_done = 1'b0;
		fu2_done = 1'b0;
		fu1_rob_idx = '0;
		fu2_rob_idx = '0;
		fu1_mispredict = 1'b0;
		fu2_mispredict = 1'b0;
		fu1_target_pc = '0;
		fu2_target_pc = '0;
	endtask

	task automatic apply_reset();
		reset = 1'b1;
		drive_idle();
		repeat (2) @(negedge clock);
		reset = 1'b0;
	endtask

	task automatic expect_equal(input logic [63:0] got, input logic [63:0] want, input string what);
		assert (got == want)
		else
		begin
			$display("mismatch at %0t: %s is %0h, expected %0h", $time, what, got, want);
			errors++;
			test_errors++;
		end
	endtask

	// called on a falling edge and returns on the next one
	task automatic dispatch(input logic thread1, input logic two, input logic br1,
			input logic accept, input rob_idx_t exp1, input rob_idx_t exp2);
		is_thread1 = thread1;
		inst1_load = 1'b1;
		inst2_load = two;
		inst1_pc = {$random(seed), $random(seed)};
		inst2_pc = {$random(seed), $random(seed)};
		inst1_arn_dest = arn_t'($unsigned($random(seed)) % 31);
		inst2_arn_dest = arn_t'($unsigned($random(seed)) % 31);
		inst1_prn_dest = prn_t'($random(seed));
		inst2_prn_dest = prn_t'($random(seed));
		inst1_is_branch = br1;
		inst2_is_branch = 1'b0;
		#1;
		expect_equal(64'(inst1_rob_idx), 64'(exp1), "inst1_rob_idx");
		expect_equal(64'(inst2_rob_idx), 64'(exp2), "inst2_rob_idx");
		if (accept)
		begin
			e_pc[exp1] = inst1_pc;
			e_arn[exp1] = inst1_arn_dest;
			e_prn[exp1] = inst1_prn_dest;
			e_br[exp1] = br1;
			if (two)
			begin
				e_pc[exp2] = inst2_pc;
				e_arn[exp2] = inst2_arn_dest;
				e_prn[exp2] = inst2_prn_dest;
				e_br[exp2] = 1'b0;
			end
		end
		@(negedge clock);
		inst1_load = 1'b0;
		inst2_load = 1'b0;
	endtask

	task automatic writeback(input rob_idx_t i1, input logic mis1, input logic use2,
			input rob_idx_t i2);
		fu1_done = 1'b1;
		fu1_rob_idx = i1;
		fu1_mispredict = mis1;
		fu1_target_pc = {$random(seed), $random(seed)};
		e_tgt[i1] = fu1_target_pc;
		e_mis[i1] = mis1;
		fu2_done = use2;
		fu2_rob_idx = i2;
		fu2_mispredict = 1'b0;
		fu2_target_pc = {$random(seed), $random(seed)};
		if (use2)
		begin
			e_tgt[i2] = fu2_target_pc;
			e_mis[i2] = 1'b0;
		end
		@(negedge clock);
		fu1_done = 1'b0;
		fu2_done = 1'b0;
	endtask

	task automatic expect_commit(input int slot, input logic valid, input rob_idx_t idx);
		logic	v;
		logic	th;
		pc_t	pc;
		pc_t	tgt;
		logic	br;
		logic	mis;
		arn_t	arn;
		prn_t	prn;
		string	tag;
		tag = $sformatf("commit%0d", slot);
		if (slot == 1)
		begin
			{v, th, pc, tgt} = {commit1_valid, commit1_is_thread1, commit1_pc, commit1_target_pc};
			{br, mis, arn, prn} = {commit1_is_branch, commit1_mispredict,
				commit1_arn_dest, commit1_prn_dest};
		end
		else
		begin
			{v, th, pc, tgt} = {commit2_valid, commit2_is_thread1, commit2_pc, commit2_target_pc};
			{br, mis, arn, prn} = {commit2_is_branch, commit2_mispredict,
				commit2_arn_dest, commit2_prn_dest};
		end
		expect_equal(64'(v), 64'(valid), {tag, " valid"});
		if (valid)
		begin
			// top bit 0 is thread 1
			expect_equal(64'(th), 64'(!idx[`ROB_IDX_W]), {tag, " is_thread1"});
			expect_equal(pc, e_pc[idx], {tag, " pc"});
			expect_equal(tgt, e_tgt[idx], {tag, " target_pc"});
			expect_equal(64'(br), 64'(e_br[idx]), {tag, " is_branch"});
			expect_equal(64'(mis), 64'(e_mis[idx]), {tag, " mispredict"});
			expect_equal(64'(arn), 64'(e_arn[idx]), {tag, " arn_dest"});
			expect_equal(64'(prn), 64'(e_prn[idx]), {tag, " prn_dest"});
		end
		else
		begin
			expect_equal(pc, 64'(0), {tag, " idle pc"});
			expect_equal(64'(arn), 64'(`ZERO_REG), {tag, " idle arn_dest"});
		end
	endtask

	task automatic wait_commit(input int limit);
		int n;
		n = 0;
		while (!commit1_valid && n < limit)
		begin
			@(negedge clock);
			n++;
		end
		assert (commit1_valid)
		else
		begin
			$display("no commit appeared within %0d cycles at %0t", limit, $time);
			errors++;
			test_errors++;
		end
	endtask

	task automatic report_test(input string name);
		tests_run++;
		if (test_errors == 0)
			$display("test %s passed", name);
		else
		begin
			$display("test %s failed with %0d errors", name, test_errors);
			tests_failed++;
		end
		test_errors = 0;
	endtask

	task automatic reset_and_index();
		apply_reset();
		expect_commit(1, 1'b0, '0);
		expect_commit(2, 1'b0, '0);
		expect_equal(64'(t1_full), 64'(0), "t1_full after reset");
		expect_equal(64'(t2_full), 64'(0), "t2_full after reset");
		dispatch(1'b1, 1'b1, 1'b0, 1'b1, 4'd0, 4'd1);
		dispatch(1'b0, 1'b1, 1'b0, 1'b1, 4'd8, 4'd9);
		report_test("reset_and_index");
	endtask

	task automatic full_flag_check();
		apply_reset();
		dispatch(1'b1, 1'b1, 1'b0, 1'b1, 4'd0, 4'd1);
		dispatch(1'b1, 1'b1, 1'b0, 1'b1, 4'd2, 4'd3);
		dispatch(1'b1, 1'b1, 1'b0, 1'b1, 4'd4, 4'd5);
		expect_equal(64'(t1_full), 64'(0), "t1_full with 2 free");
		dispatch(1'b1, 1'b0, 1'b0, 1'b1, 4'd6, 4'd0);
		expect_equal(64'(t1_full), 64'(1), "t1_full with 1 free");
		expect_equal(64'(t2_full), 64'(0), "t2_full");
		dispatch(1'b1, 1'b1, 1'b0, 1'b0, 4'd0, 4'd0);	// ignored while full
		expect_equal(64'(t1_full), 64'(1), "t1_full after ignored load");
		dispatch(1'b0, 1'b0, 1'b0, 1'b1, 4'd8, 4'd0);
		report_test("full_flag_check");
	endtask

	task automatic dual_commit_order();
		apply_reset();
		dispatch(1'b1, 1'b1, 1'b0, 1'b1, 4'd0, 4'd1);
		dispatch(1'b1, 1'b1, 1'b0, 1'b1, 4'd2, 4'd3);
		writeback(4'd3, 1'b0, 1'b1, 4'd1);
		expect_commit(1, 1'b0, '0);
		writeback(4'd2, 1'b0, 1'b0, '0);
		expect_commit(1, 1'b0, '0);
		writeback(4'd0, 1'b0, 1'b0, '0);	// head now ready and everything drains
		expect_commit(1, 1'b1, 4'd0);
		expect_commit(2, 1'b1, 4'd1);
		@(negedge clock);
		expect_commit(1, 1'b1, 4'd2);
		expect_commit(2, 1'b1, 4'd3);
		@(negedge clock);
		expect_commit(1, 1'b0, '0);
		expect_commit(2, 1'b0, '0);
		report_test("dual_commit_order");
	endtask

	task automatic thread_preference();
		apply_reset();
		dispatch(1'b1, 1'b1, 1'b0, 1'b1, 4'd0, 4'd1);
		dispatch(1'b0, 1'b0, 1'b0, 1'b1, 4'd8, 4'd0);
		writeback(4'd0, 1'b0, 1'b1, 4'd8);
		expect_commit(1, 1'b1, 4'd0);
		expect_commit(2, 1'b1, 4'd8);
		@(negedge clock);
		expect_commit(1, 1'b0, '0);
		writeback(4'd1, 1'b0, 1'b0, '0);
		wait_commit(4);
		expect_commit(1, 1'b1, 4'd1);
		expect_commit(2, 1'b0, '0);
		report_test("thread_preference");
	endtask

	task automatic mispredict_flush();
		apply_reset();
		dispatch(1'b0, 1'b1, 1'b1, 1'b1, 4'd8, 4'd9);	// branch first
		dispatch(1'b0, 1'b1, 1'b0, 1'b1, 4'd10, 4'd11);
		writeback(4'd9, 1'b0, 1'b1, 4'd10);
		expect_commit(1, 1'b0, '0);
		writeback(4'd8, 1'b1, 1'b0, '0);
		expect_commit(1, 1'b1, 4'd8);
		expect_commit(2, 1'b0, '0);
		dispatch(1'b0, 1'b0, 1'b0, 1'b0, 4'd0, 4'd0);	// thread is flushing
		expect_commit(1, 1'b0, '0);
		expect_equal(64'(t2_full), 64'(0), "t2_full after flush");
		dispatch(1'b0, 1'b0, 1'b0, 1'b1, 4'd9, 4'd0);
		expect_commit(1, 1'b0, '0);
		writeback(4'd9, 1'b0, 1'b0, '0);
		expect_commit(1, 1'b1, 4'd9);
		// thread 1 branch mispredicts while the entry behind it is ready
		dispatch(1'b1, 1'b1, 1'b1, 1'b1, 4'd0, 4'd1);
		writeback(4'd0, 1'b1, 1'b1, 4'd1);
		expect_commit(1, 1'b1, 4'd0);
		expect_commit(2, 1'b0, '0);
		@(negedge clock);
		expect_commit(1, 1'b0, '0);
		expect_equal(64'(t1_full), 64'(0), "t1_full after flush");
		report_test("mispredict_flush");
	endtask

	// watchdog allows twice the test budget plus a margin
	initial
	begin
		#((budget_cycles * 2 + 20) * period);
		$display("timeout: tests did not finish within %0d cycles", budget_cycles * 2 + 20);
		$display("Simulation failed");
		$finish;
	end

	initial
	begin
		seed = 88798;
		errors = 0;
		test_errors = 0;
		tests_run = 0;
		tests_failed = 0;
		apply_reset();
		reset_and_index();
		full_flag_check();
		dual_commit_order();
		thread_preference();
		mispredict_flush();
		errors += int'(u_dut.u_assert.error_count);
		$display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule
